// ==== verilog/tracker_pkg.sv ====
package tracker_pkg;

    localparam int TRACKER_ADDR_W = 6;   // 64 entries in the log
    localparam int NOC_W = 64;

    localparam int CHIP_ID_W = 14;
    localparam int COORD_W = 8;
    localparam int FBITS_W = 4;
    localparam int MSG_LEN_W = 8;
    localparam int MSG_TYPE_W = 8;
    localparam int META_FLITS_W = 8;
    localparam int REQ_TYPE_W = 8;

    localparam int TRACKER_FLIT_W = REQ_TYPE_W + 2 * TRACKER_ADDR_W;

    localparam int ROUTING_PAD_W = NOC_W - CHIP_ID_W - 2 * COORD_W - FBITS_W
                                 - MSG_LEN_W - MSG_TYPE_W;
    localparam int MISC_PAD_W = NOC_W - CHIP_ID_W - 2 * COORD_W - FBITS_W - META_FLITS_W;

    localparam logic [MSG_TYPE_W-1:0] TRACKER_MSG = 8'd80;

    typedef enum logic [REQ_TYPE_W-1:0] {
        META_REQ  = 8'd0,
        READ_REQ  = 8'd1,
        META_RESP = 8'd2,
        READ_RESP = 8'd3
    } tracker_req_type;

    typedef enum logic [1:0] {
        HDR_1,
        HDR_2,
        TRACKER,
        DATA
    } flit_sel_e;

    typedef struct packed {
        tracker_req_type             req_type;
        logic [TRACKER_ADDR_W-1:0]   start_addr;
        logic [TRACKER_ADDR_W-1:0]   end_addr;
    } tracker_flit;

    typedef struct packed {
        logic [CHIP_ID_W-1:0]        dst_chip_id;
        logic [COORD_W-1:0]          dst_x_coord;
        logic [COORD_W-1:0]          dst_y_coord;
        logic [FBITS_W-1:0]          dst_fbits;
        logic [MSG_LEN_W-1:0]        msg_len;   // Flits after this one
        logic [MSG_TYPE_W-1:0]       msg_type;
        logic [ROUTING_PAD_W-1:0]    rsvd;
    } routing_hdr_flit;

    typedef struct packed {
        logic [CHIP_ID_W-1:0]        src_chip_id;
        logic [COORD_W-1:0]          src_x_coord;
        logic [COORD_W-1:0]          src_y_coord;
        logic [FBITS_W-1:0]          src_fbits;
        logic [META_FLITS_W-1:0]     metadata_flits;
        logic [MISC_PAD_W-1:0]       rsvd;
    } misc_hdr_flit;

endpackage

// ==== verilog/tracker_log_if.sv ====
`timescale 1ns/1ps

interface tracker_log_if #(
    parameter int ENTRY_W = 128
);

    localparam int FLITS_PER_LINE = (ENTRY_W + tracker_pkg::NOC_W - 1) / tracker_pkg::NOC_W;
    localparam int FLIT_IDX_W = (FLITS_PER_LINE > 1) ? $clog2(FLITS_PER_LINE) : 1;

    logic                                   wr_en;
    logic [tracker_pkg::TRACKER_ADDR_W-1:0] wr_addr;
    logic [ENTRY_W-1:0]                     wr_data;
    logic [tracker_pkg::TRACKER_ADDR_W-1:0] curr_wr_addr;   // Next slot to be written
    logic                                   has_wrapped;

    logic [tracker_pkg::TRACKER_ADDR_W-1:0] rd_addr;
    logic [FLIT_IDX_W-1:0]                  rd_flit;
    logic [tracker_pkg::NOC_W-1:0]          rd_data;

    modport writer (
        output wr_en, wr_addr, wr_data, curr_wr_addr, has_wrapped
    );

    modport ram (
        input  wr_en, wr_addr, wr_data, rd_addr, rd_flit,
        output rd_data
    );

    modport reader (
        output rd_addr, rd_flit,
        input  rd_data, curr_wr_addr, has_wrapped
    );

endinterface

// ==== verilog/tracker_log_writer.sv ====
`timescale 1ns/1ps

module tracker_log_writer #(
    parameter int ENTRY_W = 128
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 log_val,
    input  logic [ENTRY_W-1:0]   log_data,

    tracker_log_if.writer        log
);

    logic [tracker_pkg::TRACKER_ADDR_W-1:0] wr_ptr_reg;
    logic                                   wrapped_reg;
    logic                                   ptr_at_end;

    assign ptr_at_end = (wr_ptr_reg == '1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_reg <= '0;
            wrapped_reg <= 1'b0;
        end else if (log_val) begin
            wr_ptr_reg <= wr_ptr_reg + 1'b1;   // Rolls over to 0 after the last slot
            if (ptr_at_end) begin
                wrapped_reg <= 1'b1;   // Stays set until reset
            end
        end
    end

    // The entry lands in the buffer on the same edge that moves the pointer
    assign log.wr_en = log_val;
    assign log.wr_addr = wr_ptr_reg;
    assign log.wr_data = log_data;

    assign log.curr_wr_addr = wr_ptr_reg;
    assign log.has_wrapped = wrapped_reg;

endmodule

// ==== verilog/tracker_log_ram.sv ====
`timescale 1ns/1ps

module tracker_log_ram #(
    parameter int ENTRY_W = 128
) (
    input  logic        clk,

    tracker_log_if.ram  log
);

    localparam int DEPTH = 1 << tracker_pkg::TRACKER_ADDR_W;
    localparam int FLITS_PER_LINE = (ENTRY_W + tracker_pkg::NOC_W - 1) / tracker_pkg::NOC_W;
    localparam int FLIT_IDX_W = (FLITS_PER_LINE > 1) ? $clog2(FLITS_PER_LINE) : 1;
    localparam int LINE_W = FLITS_PER_LINE * tracker_pkg::NOC_W;

    logic [ENTRY_W-1:0]     mem [DEPTH];
    logic [ENTRY_W-1:0]     rd_entry_reg;
    logic [FLIT_IDX_W-1:0]  rd_flit_reg;
    logic [LINE_W-1:0]      rd_line;

    always_ff @(posedge clk) begin
        if (log.wr_en) begin
            mem[log.wr_addr] <= log.wr_data;
        end
        rd_entry_reg <= mem[log.rd_addr];
        rd_flit_reg <= log.rd_flit;
    end

    // Entry is left-aligned so flit 0 always carries the top bits
    assign rd_line = LINE_W'(rd_entry_reg) << (LINE_W - ENTRY_W);

    assign log.rd_data = rd_line[(FLITS_PER_LINE - 1 - int'(rd_flit_reg)) * tracker_pkg::NOC_W
                                 +: tracker_pkg::NOC_W];

endmodule

// ==== verilog/tracker_read_ctrl.sv ====
`timescale 1ns/1ps

module tracker_read_ctrl #(
    parameter int ENTRY_W = 128
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            noc_in_val,
    output logic                            noc_out_val,

    tracker_log_if.reader                   log,

    output logic                            incr_rd_addr,
    output logic                            store_req,
    output logic                            store_flit_2,
    output tracker_pkg::flit_sel_e          output_flit_sel,

    input  tracker_pkg::tracker_req_type    req_type,
    input  logic                            last_entry
);

    localparam int FLITS_PER_LINE = (ENTRY_W + tracker_pkg::NOC_W - 1) / tracker_pkg::NOC_W;
    localparam int FLIT_IDX_W = (FLITS_PER_LINE > 1) ? $clog2(FLITS_PER_LINE) : 1;
    localparam logic [FLIT_IDX_W-1:0] LAST_FLIT = FLIT_IDX_W'(FLITS_PER_LINE - 1);

    typedef enum logic [2:0] {
        IDLE,
        RX_HDR2,
        RX_TRACKER,
        TX_HDR1,
        TX_HDR2,
        TX_TRACKER,
        TX_DATA
    } state_e;

    state_e                 state_reg;
    state_e                 state_next;
    logic [FLIT_IDX_W-1:0]  flit_cnt_reg;
    logic [FLIT_IDX_W-1:0]  flit_cnt_next;
    logic                   line_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_reg <= IDLE;
            flit_cnt_reg <= '0;
        end else begin
            state_reg <= state_next;
            flit_cnt_reg <= flit_cnt_next;
        end
    end

    assign line_done = (state_reg == TX_DATA) && (flit_cnt_reg == LAST_FLIT);
    assign incr_rd_addr = line_done;

    // Outside TX_DATA the next data flit is always flit 0 of an entry
    assign flit_cnt_next = ((state_reg == TX_DATA) && !line_done) ? flit_cnt_reg + 1'b1 : '0;
    assign log.rd_flit = flit_cnt_next;   // Buffer sees next cycle's flit index

    always_comb begin
        state_next = state_reg;
        store_flit_2 = 1'b0;
        store_req = 1'b0;
        noc_out_val = 1'b0;
        output_flit_sel = tracker_pkg::HDR_1;
        case (state_reg)
            IDLE: begin
                if (noc_in_val) begin
                    state_next = RX_HDR2;   // Routing header of the request is not kept
                end
            end
            RX_HDR2: begin
                if (noc_in_val) begin
                    store_flit_2 = 1'b1;
                    state_next = RX_TRACKER;
                end
            end
            RX_TRACKER: begin
                if (noc_in_val) begin
                    store_req = 1'b1;
                    state_next = TX_HDR1;
                end
            end
            TX_HDR1: begin
                noc_out_val = 1'b1;
                output_flit_sel = tracker_pkg::HDR_1;
                state_next = TX_HDR2;
            end
            TX_HDR2: begin
                noc_out_val = 1'b1;
                output_flit_sel = tracker_pkg::HDR_2;
                state_next = TX_TRACKER;
            end
            TX_TRACKER: begin
                noc_out_val = 1'b1;
                output_flit_sel = tracker_pkg::TRACKER;
                state_next = (req_type == tracker_pkg::READ_REQ) ? TX_DATA : IDLE;
            end
            TX_DATA: begin
                noc_out_val = 1'b1;
                output_flit_sel = tracker_pkg::DATA;
                if (line_done && last_entry) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// ==== verilog/tracker_read_datap.sv ====
`timescale 1ns/1ps

module tracker_read_datap #(
    parameter int SRC_X = 0,
    parameter int SRC_Y = 0,
    parameter int ENTRY_W = 128
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [tracker_pkg::NOC_W-1:0]   noc_reader_in_data,
    output logic [tracker_pkg::NOC_W-1:0]   reader_out_noc_data,

    tracker_log_if.reader                   log,

    input  logic                            incr_rd_addr,
    input  logic                            store_req,
    input  logic                            store_flit_2,
    input  tracker_pkg::flit_sel_e          output_flit_sel,

    output tracker_pkg::tracker_req_type    datap_ctrl_req_type,
    output logic                            datap_ctrl_last_entry
);

    localparam int FLITS_PER_LINE = (ENTRY_W + tracker_pkg::NOC_W - 1) / tracker_pkg::NOC_W;
    localparam int ADDR_W = tracker_pkg::TRACKER_ADDR_W;
    localparam int PAD_W = tracker_pkg::NOC_W - tracker_pkg::TRACKER_FLIT_W;

    logic [ADDR_W-1:0]              curr_read_reg;
    logic [ADDR_W-1:0]              curr_read_next;
    logic [ADDR_W-1:0]              num_entries;

    tracker_pkg::tracker_flit       flit_req_reg;
    tracker_pkg::tracker_flit       flit_req_next;
    tracker_pkg::misc_hdr_flit      misc_req_reg;
    tracker_pkg::misc_hdr_flit      misc_req_next;

    tracker_pkg::tracker_flit       meta_resp;
    tracker_pkg::tracker_flit       read_resp;
    tracker_pkg::routing_hdr_flit   hdr_1;
    tracker_pkg::misc_hdr_flit      hdr_2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flit_req_reg <= '0;
        end else begin
            flit_req_reg <= flit_req_next;
        end
    end

    always_ff @(posedge clk) begin
        curr_read_reg <= curr_read_next;
        misc_req_reg <= misc_req_next;
    end

    // Tracker flit of the request sits in the top bits
    assign flit_req_next = store_req
                         ? noc_reader_in_data[tracker_pkg::NOC_W-1 -: tracker_pkg::TRACKER_FLIT_W]
                         : flit_req_reg;

    assign misc_req_next = store_flit_2 ? noc_reader_in_data : misc_req_reg;

    assign curr_read_next = store_req    ? flit_req_next.start_addr :
                            incr_rd_addr ? curr_read_reg + 1'b1 :
                                           curr_read_reg;

    assign log.rd_addr = curr_read_next;   // One cycle ahead to cover the buffer latency

    assign datap_ctrl_req_type = flit_req_reg.req_type;
    assign datap_ctrl_last_entry = (curr_read_next == flit_req_reg.end_addr);

    assign num_entries = flit_req_reg.end_addr - flit_req_reg.start_addr;   // Modulo the depth

    always_comb begin
        meta_resp = '0;
        meta_resp.req_type = tracker_pkg::META_RESP;
        meta_resp.start_addr = log.has_wrapped ? log.curr_wr_addr : '0;
        meta_resp.end_addr = log.curr_wr_addr;
    end

    always_comb begin
        read_resp = '0;
        read_resp.req_type = tracker_pkg::READ_RESP;
        read_resp.start_addr = flit_req_reg.start_addr;
        read_resp.end_addr = flit_req_reg.end_addr;
    end

    always_comb begin
        hdr_1 = '0;
        hdr_1.dst_chip_id = misc_req_reg.src_chip_id;
        hdr_1.dst_x_coord = misc_req_reg.src_x_coord;
        hdr_1.dst_y_coord = misc_req_reg.src_y_coord;
        hdr_1.dst_fbits = misc_req_reg.src_fbits;
        // Misc header and tracker flit, then the data flits
        hdr_1.msg_len = (flit_req_reg.req_type == tracker_pkg::READ_REQ)
                      ? tracker_pkg::MSG_LEN_W'(2 + num_entries * FLITS_PER_LINE)
                      : tracker_pkg::MSG_LEN_W'(2);
        hdr_1.msg_type = tracker_pkg::TRACKER_MSG;
    end

    always_comb begin
        hdr_2 = '0;
        hdr_2.src_x_coord = tracker_pkg::COORD_W'(SRC_X);
        hdr_2.src_y_coord = tracker_pkg::COORD_W'(SRC_Y);
        hdr_2.metadata_flits = tracker_pkg::META_FLITS_W'(1);   // The tracker flit
    end

    always_comb begin
        case (output_flit_sel)
            tracker_pkg::HDR_1: begin
                reader_out_noc_data = hdr_1;
            end
            tracker_pkg::HDR_2: begin
                reader_out_noc_data = hdr_2;
            end
            tracker_pkg::TRACKER: begin
                if (flit_req_reg.req_type == tracker_pkg::READ_REQ) begin
                    reader_out_noc_data = {read_resp, {PAD_W{1'b0}}};
                end else begin
                    reader_out_noc_data = {meta_resp, {PAD_W{1'b0}}};
                end
            end
            default: begin
                reader_out_noc_data = log.rd_data;
            end
        endcase
    end

endmodule

// ==== verilog/tracker_top.sv ====
`timescale 1ns/1ps

module tracker_top #(
    parameter int ENTRY_W = 128,
    parameter int SRC_X = 3,
    parameter int SRC_Y = 5
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            log_val,
    input  logic [ENTRY_W-1:0]              log_data,

    input  logic                            noc_in_val,
    input  logic [tracker_pkg::NOC_W-1:0]   noc_in_data,

    output logic                            noc_out_val,
    output logic [tracker_pkg::NOC_W-1:0]   noc_out_data
);

    logic                           incr_rd_addr;
    logic                           store_req;
    logic                           store_flit_2;
    tracker_pkg::flit_sel_e         output_flit_sel;
    tracker_pkg::tracker_req_type   req_type;
    logic                           last_entry;

    tracker_log_if #(.ENTRY_W(ENTRY_W)) log_bus ();

    tracker_log_writer #(
        .ENTRY_W    (ENTRY_W)
    ) u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .log_val    (log_val),
        .log_data   (log_data),
        .log        (log_bus.writer)
    );

    tracker_log_ram #(
        .ENTRY_W    (ENTRY_W)
    ) u_ram (
        .clk        (clk),
        .log        (log_bus.ram)
    );

    tracker_read_ctrl #(
        .ENTRY_W            (ENTRY_W)
    ) u_read_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .noc_in_val         (noc_in_val),
        .noc_out_val        (noc_out_val),
        .log                (log_bus.reader),   // Drives rd_flit only
        .incr_rd_addr       (incr_rd_addr),
        .store_req          (store_req),
        .store_flit_2       (store_flit_2),
        .output_flit_sel    (output_flit_sel),
        .req_type           (req_type),
        .last_entry         (last_entry)
    );

    tracker_read_datap #(
        .SRC_X                  (SRC_X),
        .SRC_Y                  (SRC_Y),
        .ENTRY_W                (ENTRY_W)
    ) u_read_datap (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .noc_reader_in_data     (noc_in_data),
        .reader_out_noc_data    (noc_out_data),
        .log                    (log_bus.reader),   // Drives rd_addr only
        .incr_rd_addr           (incr_rd_addr),
        .store_req              (store_req),
        .store_flit_2           (store_flit_2),
        .output_flit_sel        (output_flit_sel),
        .datap_ctrl_req_type    (req_type),
        .datap_ctrl_last_entry  (last_entry)
    );

endmodule

// ==== dv/tracker_chk.sv ====
`timescale 1ns/1ps

module tracker_chk (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    log_val,
    input  logic                                    noc_out_val,
    input  logic [tracker_pkg::NOC_W-1:0]           noc_out_data,
    input  logic [tracker_pkg::TRACKER_ADDR_W-1:0]  curr_wr_addr
);

    tracker_pkg::routing_hdr_flit       out_hdr;
    logic [tracker_pkg::MSG_LEN_W-1:0]  flits_left;   // Flits still owed by the current message

    assign out_hdr = noc_out_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flits_left <= '0;
        end else if (flits_left != '0) begin
            flits_left <= flits_left - 1'b1;
        end else if (noc_out_val) begin
            flits_left <= out_hdr.msg_len;   // A flit seen here is always a routing header
        end
    end

    out_low_in_reset: assert property (@(posedge clk) !rst_n |=> !noc_out_val)
        else $error("noc_out_val went high while in reset");

    no_gap_in_msg: assert property (@(posedge clk) disable iff (!rst_n)
        (flits_left != '0) |-> noc_out_val)
        else $error("Gap in the response before msg_len flits were sent");

    wr_ptr_on_log: assert property (@(posedge clk) disable iff (!rst_n)
        !log_val |=> $stable(curr_wr_addr))
        else $error("curr_wr_addr moved without log_val");

endmodule

bind tracker_top tracker_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .log_val        (log_val),
    .noc_out_val    (noc_out_val),
    .noc_out_data   (noc_out_data),
    .curr_wr_addr   (log_bus.curr_wr_addr)
);

// ==== dv/tracker_tb.sv ====
`timescale 1ns/1ps

module tracker_tb;

    localparam int ENTRY_W = 128;
    localparam int SRC_X = 3;
    localparam int SRC_Y = 5;
    localparam int NOC_W = tracker_pkg::NOC_W;
    localparam int ADDR_W = tracker_pkg::TRACKER_ADDR_W;
    localparam int FLITS_PER_LINE = (ENTRY_W + NOC_W - 1) / NOC_W;
    localparam int PAD_W = NOC_W - tracker_pkg::TRACKER_FLIT_W;
    localparam int MAX_CYCLES = 2000;   // Patterns take about 400 cycles with the longest gaps

    logic                   clk;
    logic                   rst_n;
    logic                   log_val;
    logic [ENTRY_W-1:0]     log_data;
    logic                   noc_in_val;
    logic [NOC_W-1:0]       noc_in_data;
    logic                   noc_out_val;
    logic [NOC_W-1:0]       noc_out_data;

    logic [63:0]            patterns [32];
    logic [ENTRY_W-1:0]     model_log [1 << ADDR_W];
    logic [ADDR_W-1:0]      model_wr_ptr;
    int                     log_count;
    int                     cycle_count;

    tracker_top #(
        .ENTRY_W        (ENTRY_W),
        .SRC_X          (SRC_X),
        .SRC_Y          (SRC_Y)
    ) dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .log_val        (log_val),
        .log_data       (log_data),
        .noc_in_val     (noc_in_val),
        .noc_in_data    (noc_in_data),
        .noc_out_val    (noc_out_val),
        .noc_out_data   (noc_out_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            stop_run($sformatf("Timeout after %0d cycles without finishing", MAX_CYCLES));
        end
    end

    task automatic check_flit(input string name, input logic [NOC_W-1:0] exp,
                              input logic [NOC_W-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_routing(input string name, input tracker_pkg::routing_hdr_flit exp,
                                 input tracker_pkg::routing_hdr_flit act);
        if (act.dst_chip_id !== exp.dst_chip_id || act.dst_x_coord !== exp.dst_x_coord ||
            act.dst_y_coord !== exp.dst_y_coord || act.dst_fbits !== exp.dst_fbits ||
            act.msg_len !== exp.msg_len || act.msg_type !== exp.msg_type) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_tracker(input string name, input tracker_pkg::tracker_flit exp,
                                 input tracker_pkg::tracker_flit act);
        if (act !== exp) begin
            stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Each request comes from a different tile so the return address is visible
    function automatic tracker_pkg::misc_hdr_flit requester_of(input int idx);
        tracker_pkg::misc_hdr_flit misc;
        misc = '0;
        misc.src_chip_id = 14'(16'h0100 + idx);
        misc.src_x_coord = 8'(idx + 1);
        misc.src_y_coord = 8'h09;
        misc.src_fbits = 4'h6;
        return misc;
    endfunction

    task automatic log_entries(input logic [31:0] key, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            log_val = 1'b1;
            log_data = {key, 32'(log_count), ~key, 32'(log_count) * 32'h9e3779b1};
            model_log[model_wr_ptr] = log_data;
            model_wr_ptr = model_wr_ptr + 1'b1;
            log_count++;
            @(negedge clk);
        end
        log_val = 1'b0;
    endtask

    task automatic drive_flit(input logic [NOC_W-1:0] flit, input bit gap);
        int idle;
        idle = gap ? int'($urandom % 4) : 0;
        repeat (idle) @(negedge clk);
        noc_in_val = 1'b1;
        noc_in_data = flit;
        @(negedge clk);
        noc_in_val = 1'b0;
    endtask

    task automatic send_request(input int req_idx, input logic [63:0] rec);
        tracker_pkg::routing_hdr_flit hdr;
        tracker_pkg::tracker_flit trk;
        hdr = '0;
        hdr.dst_x_coord = 8'(SRC_X);
        hdr.dst_y_coord = 8'(SRC_Y);
        hdr.msg_len = 8'd2;
        hdr.msg_type = tracker_pkg::TRACKER_MSG;
        trk.req_type = tracker_pkg::tracker_req_type'(rec[55:48]);
        trk.start_addr = rec[45:40];
        trk.end_addr = rec[37:32];
        drive_flit(hdr, rec[0]);
        drive_flit(requester_of(req_idx), rec[0]);
        drive_flit({trk, {PAD_W{1'b0}}}, rec[0]);
    endtask

    task automatic check_response(input int req_idx, input logic [63:0] rec);
        tracker_pkg::routing_hdr_flit exp_hdr;
        tracker_pkg::routing_hdr_flit act_hdr;
        tracker_pkg::misc_hdr_flit req_misc;
        tracker_pkg::misc_hdr_flit act_misc;
        tracker_pkg::tracker_flit exp_trk;
        tracker_pkg::tracker_flit act_trk;
        logic [ADDR_W-1:0] addr;
        int n_flits;
        int k;
        int d;
        string name;
        name = $sformatf("req%0d", req_idx);
        req_misc = requester_of(req_idx);
        exp_hdr = '0;
        exp_hdr.dst_chip_id = req_misc.src_chip_id;
        exp_hdr.dst_x_coord = req_misc.src_x_coord;
        exp_hdr.dst_y_coord = req_misc.src_y_coord;
        exp_hdr.dst_fbits = req_misc.src_fbits;
        exp_hdr.msg_len = rec[31:24];
        exp_hdr.msg_type = tracker_pkg::TRACKER_MSG;
        exp_trk.req_type = (tracker_pkg::tracker_req_type'(rec[55:48]) == tracker_pkg::READ_REQ)
                         ? tracker_pkg::READ_RESP : tracker_pkg::META_RESP;
        exp_trk.start_addr = rec[21:16];
        exp_trk.end_addr = rec[13:8];
        n_flits = int'(rec[31:24]) + 1;   // Header plus msg_len flits
        while (!noc_out_val) @(negedge clk);
        for (k = 0; k < n_flits; k++) begin
            if (!noc_out_val) begin
                stop_run($sformatf("%s response stopped after %0d of %0d flits",
                                   name, k, n_flits));
            end
            if (k == 0) begin
                act_hdr = noc_out_data;
                check_routing({name, " routing header"}, exp_hdr, act_hdr);
            end else if (k == 1) begin
                act_misc = noc_out_data;
                check_flit({name, " src x"}, 64'(SRC_X), 64'(act_misc.src_x_coord));
                check_flit({name, " src y"}, 64'(SRC_Y), 64'(act_misc.src_y_coord));
            end else if (k == 2) begin
                act_trk = noc_out_data[NOC_W-1 -: tracker_pkg::TRACKER_FLIT_W];
                check_tracker({name, " tracker flit"}, exp_trk, act_trk);
            end else begin
                d = k - 3;
                addr = ADDR_W'(int'(rec[47:40]) + d / FLITS_PER_LINE);   // Wraps at 64
                check_flit($sformatf("%s data %0d (entry %0d)", name, d, addr),
                           model_log[addr][ENTRY_W-1 - (d % FLITS_PER_LINE) * NOC_W -: NOC_W],
                           noc_out_data);
            end
            @(negedge clk);
        end
        if (noc_out_val) begin
            stop_run($sformatf("%s response has more than %0d flits", name, n_flits));
        end
    endtask

    initial begin
        int idx;
        int n_req;
        logic [63:0] rec;
        void'($urandom(32'h3d0a));
        rst_n = 1'b0;
        log_val = 1'b0;
        log_data = '0;
        noc_in_val = 1'b0;
        noc_in_data = '0;
        model_wr_ptr = '0;
        log_count = 0;
        $readmemh("dv/tracker_patterns.hex", patterns);
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        idx = 0;
        n_req = 0;
        while (patterns[idx][63:56] != 8'h00) begin
            rec = patterns[idx];
            if (rec[63:56] == 8'h01) begin
                log_entries(rec[47:16], int'(rec[15:0]));
            end else if (rec[63:56] == 8'h02) begin
                send_request(n_req, rec);
                check_response(n_req, rec);
                n_req++;
            end else begin
                stop_run($sformatf("Pattern record %0d has an unknown opcode %h",
                                   idx, rec[63:56]));
            end
            idx++;
        end
        if (n_req == 0) begin
            stop_run("The pattern file holds no requests");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== dv/tracker_patterns.hex ====
// Log:     [63:56]=01 [47:16]=data key [15:0]=entry count
// Request: [63:56]=02 [55:48]=type [47:40]=start [39:32]=end [31:24]=msg_len
//          [23:16]=resp start [15:8]=resp end [0]=random gaps between request flits
// A record of all zeros ends the list
// Ten entries, then the plain window and a read of entries 2 to 6
0100a5c31e70000a
0200000002000a00
020102060a020600
// Sixty more entries wrap the log, pointer ends at 6
01003b9d47e2003c
0200000002060600
// Read across the wrap point, 60 to 3
02013c03103c0300
// Back-to-back requests with gaps between request flits
02010a0e0a0a0e01
0200000002060601
02013f01063f0101
0201050480050401
0200000002060601
0000000000000000

// ==== build.f ====
verilog/tracker_pkg.sv
verilog/tracker_log_if.sv
verilog/tracker_log_writer.sv
verilog/tracker_log_ram.sv
verilog/tracker_read_ctrl.sv
verilog/tracker_read_datap.sv
verilog/tracker_top.sv
dv/tracker_chk.sv
dv/tracker_tb.sv

// ==== sim.sh ====
#!/bin/sh
# Compile and run the tracker testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tracker_tb -f build.f -o tracker_sim
./obj_dir/tracker_sim
